//--- gba_mem_pkg.sv
`default_nettype none

package gba_mem_pkg;

    // Bus data and address word
    typedef logic [31:0] word_t;

    // One write enable per byte lane
    typedef logic [3:0] byte_en_t;

    // Access size of a bus write, code 3 writes nothing
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_t;

    // Region codes in address bits 31:24
    localparam logic [7:0] region_intern  = 8'h03;
    localparam logic [7:0] region_io      = 8'h04;
    localparam logic [7:0] region_palette = 8'h05;
    localparam logic [7:0] region_vram    = 8'h06;

    // Internal RAM is 1024 words, mirrored every 4 KB
    localparam int intern_addr_bits = 10;

    // Each palette half is 128 words, bit 9 picks the object half
    localparam int palette_addr_bits = 7;

    // Single VRAM bank of 2048 words, mirrored every 8 KB
    localparam int vram_addr_bits = 11;

    // I/O register file covers offsets 0x000 to 0x20F
    localparam int io_num_regs = 132;

    // Word indices of the registers with read-only halves
    localparam int io_vcount_idx   = 1;
    localparam int io_keyinput_idx = 76;
    localparam int io_if_idx       = 128;

endpackage

`default_nettype wire

//--- dual_port_ram.sv
`default_nettype none

module dual_port_ram
    import gba_mem_pkg::*;
#(
    parameter int addr_bits = 10
) (
    input  logic                 clock,
    input  logic [addr_bits-1:0] a_addr,
    input  byte_en_t             a_we,
    input  word_t                a_wdata,
    output word_t                a_rdata,
    input  logic [addr_bits-1:0] b_addr,
    output word_t                b_rdata
);

    word_t mem [2**addr_bits];
    word_t a_merged;

    // Enabled lanes take the new data, the rest keep the stored word
    always_comb begin
        a_merged = mem[a_addr];
        for (int b = 0; b < 4; b++) begin
            if (a_we[b]) begin
                a_merged[8*b +: 8] = a_wdata[8*b +: 8];
            end
        end
    end

    // Port a is write-first, so a write returns the merged word
    always_ff @(posedge clock) begin
        if (a_we != '0) begin
            mem[a_addr] <= a_merged;
        end
        a_rdata <= a_merged;
        b_rdata <= mem[b_addr];
    end

endmodule

`default_nettype wire

//--- bus_front_end.sv
`default_nettype none

module bus_front_end
    import gba_mem_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  word_t     bus_addr,
    input  mem_size_t bus_size,
    input  logic      bus_write,
    output logic      bus_pause,
    output word_t     addr_lat,
    output word_t     ram_addr,
    output byte_en_t  byte_we
);

    mem_size_t size_lat;

    // Request registers, the pause flop doubles as the latched write flag
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            addr_lat  <= '0;
            size_lat  <= size_byte;
            bus_pause <= 1'b0;
        end else begin
            addr_lat  <= bus_addr;
            size_lat  <= bus_size;
            // A held write must not start a second pause
            bus_pause <= bus_write & ~bus_pause;
        end
    end

    // The write commits from the latched address during the pause
    assign ram_addr = bus_pause ? addr_lat : bus_addr;

    // Byte lane enables, only live in the pause cycle
    always_comb begin
        byte_we = '0;
        if (bus_pause) begin
            case (size_lat)
                size_byte: byte_we[addr_lat[1:0]] = 1'b1;
                size_half: byte_we = addr_lat[1] ? 4'b1100 : 4'b0011;
                size_word: byte_we = 4'b1111;
                default:   byte_we = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- palette_mem.sv
`default_nettype none

module palette_mem
    import gba_mem_pkg::*;
(
    input  logic     clock,
    input  logic     select,
    input  word_t    addr_lat,
    input  word_t    ram_addr,
    input  byte_en_t byte_we,
    input  word_t    bus_wdata,
    output word_t    bus_rdata,
    input  word_t    gfx_palette_bg_addr,
    output word_t    gfx_palette_bg_data,
    input  word_t    gfx_palette_obj_addr,
    output word_t    gfx_palette_obj_data
);

    logic     obj_half;
    byte_en_t bg_we;
    byte_en_t obj_we;
    word_t    bg_rdata;
    word_t    obj_rdata;

    // Address bit 9 splits the palette into background and object halves
    assign obj_half = addr_lat[9];
    assign bg_we    = (select && !obj_half) ? byte_we : '0;
    assign obj_we   = (select && obj_half) ? byte_we : '0;

    dual_port_ram #(
        .addr_bits(palette_addr_bits)
    ) i_bg_ram (
        .clock  (clock),
        .a_addr (ram_addr[palette_addr_bits+1:2]),
        .a_we   (bg_we),
        .a_wdata(bus_wdata),
        .a_rdata(bg_rdata),
        .b_addr (gfx_palette_bg_addr[palette_addr_bits+1:2]),
        .b_rdata(gfx_palette_bg_data)
    );

    dual_port_ram #(
        .addr_bits(palette_addr_bits)
    ) i_obj_ram (
        .clock  (clock),
        .a_addr (ram_addr[palette_addr_bits+1:2]),
        .a_we   (obj_we),
        .a_wdata(bus_wdata),
        .a_rdata(obj_rdata),
        .b_addr (gfx_palette_obj_addr[palette_addr_bits+1:2]),
        .b_rdata(gfx_palette_obj_data)
    );

    // Read word of the half that was addressed
    assign bus_rdata = !select ? '0 : (obj_half ? obj_rdata : bg_rdata);

endmodule

`default_nettype wire

//--- vram_mem.sv
`default_nettype none

module vram_mem
    import gba_mem_pkg::*;
(
    input  logic     clock,
    input  logic     select,
    input  word_t    addr_lat,
    input  word_t    ram_addr,
    input  byte_en_t byte_we,
    input  word_t    bus_wdata,
    output word_t    bus_rdata,
    input  word_t    gfx_vram_addr,
    output word_t    gfx_vram_data
);

    byte_en_t vram_we;
    word_t    vram_rdata;

    // The bank mirrors every 8 KB, so any offset in the region hits it
    assign vram_we = select ? byte_we : '0;

    dual_port_ram #(
        .addr_bits(vram_addr_bits)
    ) i_vram_ram (
        .clock  (clock),
        .a_addr (ram_addr[vram_addr_bits+1:2]),
        .a_we   (vram_we),
        .a_wdata(bus_wdata),
        .a_rdata(vram_rdata),
        .b_addr (gfx_vram_addr[vram_addr_bits+1:2]),
        .b_rdata(gfx_vram_data)
    );

    assign bus_rdata = select ? vram_rdata : '0;

endmodule

`default_nettype wire

//--- io_registers.sv
`default_nettype none

module io_registers
    import gba_mem_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        select,
    input  word_t       addr_lat,
    input  byte_en_t    byte_we,
    input  word_t       bus_wdata,
    output word_t       bus_rdata,
    input  logic [15:0] buttons,
    input  logic [15:0] vcount,
    input  logic [15:0] reg_if,
    output logic [15:0] int_acks
);

    word_t       regs [io_num_regs];
    word_t       read_word;
    logic [7:0]  reg_idx;
    logic        in_range;
    logic        reg_hit;
    logic        ack_hit;

    // Word index of the latched offset, anything past 0x20F is unmapped
    assign reg_idx  = addr_lat[9:2];
    assign in_range = (addr_lat[23:10] == '0) && (reg_idx < 8'(io_num_regs));
    assign reg_hit  = select && in_range;
    assign ack_hit  = reg_hit && (reg_idx == 8'(io_if_idx));

    // Byte-lane writes into the register file
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < io_num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_hit) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_we[b]) begin
                    regs[reg_idx][8*b +: 8] <= bus_wdata[8*b +: 8];
                end
            end
        end
    end

    // Acknowledge half of IE/IF, cleared each cycle unless written
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            int_acks <= '0;
        end else begin
            for (int b = 0; b < 2; b++) begin
                if (ack_hit && byte_we[b+2]) begin
                    int_acks[8*b +: 8] <= bus_wdata[16 + 8*b +: 8];
                end else begin
                    int_acks[8*b +: 8] <= 8'h00;
                end
            end
        end
    end

    // Read-only halves replace the stored bits on reads
    always_comb begin
        if (!reg_hit) begin
            read_word = '0;
        end else if (reg_idx == 8'(io_keyinput_idx)) begin
            read_word = {regs[reg_idx][31:16], buttons};
        end else if (reg_idx == 8'(io_vcount_idx)) begin
            read_word = {vcount, regs[reg_idx][15:0]};
        end else if (reg_idx == 8'(io_if_idx)) begin
            // Enable in the low half, pending flags in the high half
            read_word = {reg_if, regs[reg_idx][15:0]};
        end else begin
            read_word = regs[reg_idx];
        end
    end

    assign bus_rdata = read_word;

endmodule

`default_nettype wire

//--- mem_top.sv
`default_nettype none

module mem_top
    import gba_mem_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  word_t       bus_addr,
    input  word_t       bus_wdata,
    output word_t       bus_rdata,
    input  mem_size_t   bus_size,
    output logic        bus_pause,
    input  logic        bus_write,
    input  word_t       gfx_vram_addr,
    output word_t       gfx_vram_data,
    input  word_t       gfx_palette_bg_addr,
    output word_t       gfx_palette_bg_data,
    input  word_t       gfx_palette_obj_addr,
    output word_t       gfx_palette_obj_data,
    input  logic [15:0] buttons,
    input  logic [15:0] vcount,
    input  logic [15:0] reg_if,
    output logic [15:0] int_acks
);

    word_t    addr_lat;
    word_t    ram_addr;
    byte_en_t byte_we;
    byte_en_t intern_we;
    word_t    intern_rdata;
    word_t    palette_rdata;
    word_t    vram_rdata;
    word_t    io_rdata;
    logic     sel_intern;
    logic     sel_io;
    logic     sel_palette;
    logic     sel_vram;

    bus_front_end i_front_end (
        .clock    (clock),
        .reset    (reset),
        .bus_addr (bus_addr),
        .bus_size (bus_size),
        .bus_write(bus_write),
        .bus_pause(bus_pause),
        .addr_lat (addr_lat),
        .ram_addr (ram_addr),
        .byte_we  (byte_we)
    );

    // Region decode on the latched address
    assign sel_intern  = addr_lat[31:24] == region_intern;
    assign sel_io      = addr_lat[31:24] == region_io;
    assign sel_palette = addr_lat[31:24] == region_palette;
    assign sel_vram    = addr_lat[31:24] == region_vram;

    // Internal RAM, 4 KB mirrored over the region, bus port only
    assign intern_we = sel_intern ? byte_we : '0;

    dual_port_ram #(
        .addr_bits(intern_addr_bits)
    ) i_intern_ram (
        .clock  (clock),
        .a_addr (ram_addr[intern_addr_bits+1:2]),
        .a_we   (intern_we),
        .a_wdata(bus_wdata),
        .a_rdata(intern_rdata),
        .b_addr ('0),
        .b_rdata()
    );

    palette_mem i_palette (
        .clock               (clock),
        .select              (sel_palette),
        .addr_lat            (addr_lat),
        .ram_addr            (ram_addr),
        .byte_we             (byte_we),
        .bus_wdata           (bus_wdata),
        .bus_rdata           (palette_rdata),
        .gfx_palette_bg_addr (gfx_palette_bg_addr),
        .gfx_palette_bg_data (gfx_palette_bg_data),
        .gfx_palette_obj_addr(gfx_palette_obj_addr),
        .gfx_palette_obj_data(gfx_palette_obj_data)
    );

    vram_mem i_vram (
        .clock        (clock),
        .select       (sel_vram),
        .addr_lat     (addr_lat),
        .ram_addr     (ram_addr),
        .byte_we      (byte_we),
        .bus_wdata    (bus_wdata),
        .bus_rdata    (vram_rdata),
        .gfx_vram_addr(gfx_vram_addr),
        .gfx_vram_data(gfx_vram_data)
    );

    io_registers i_io (
        .clock    (clock),
        .reset    (reset),
        .select   (sel_io),
        .addr_lat (addr_lat),
        .byte_we  (byte_we),
        .bus_wdata(bus_wdata),
        .bus_rdata(io_rdata),
        .buttons  (buttons),
        .vcount   (vcount),
        .reg_if   (reg_if),
        .int_acks (int_acks)
    );

    // Region read words are zero when unselected, unmapped reads give zero
    assign bus_rdata = (sel_intern ? intern_rdata : '0)
                     | palette_rdata
                     | vram_rdata
                     | io_rdata;

endmodule

`default_nettype wire

//--- mem_top_assert.sv
`default_nettype none

module mem_top_assert (
    input logic        clock,
    input logic        reset,
    input logic        bus_write,
    input logic        bus_pause,
    input logic [15:0] int_acks
);

    // A new write outside a pause starts a pause on the next cycle
    pause_after_write: assert property (
        @(posedge clock) disable iff (reset)
        ($rose(bus_write) && !bus_pause) |=> bus_pause
    ) else $error("bus_pause did not follow a new write");

    // Every write holds the bus for one cycle only
    pause_one_cycle: assert property (
        @(posedge clock) disable iff (reset)
        bus_pause |=> !bus_pause
    ) else $error("bus_pause stayed high for two cycles");

    // Acknowledge is a single-cycle pulse
    ack_one_cycle: assert property (
        @(posedge clock) disable iff (reset)
        (int_acks != '0) |=> (int_acks == '0)
    ) else $error("int_acks stayed nonzero for two cycles");

endmodule

bind mem_top mem_top_assert i_mem_top_assert (
    .clock    (clock),
    .reset    (reset),
    .bus_write(bus_write),
    .bus_pause(bus_pause),
    .int_acks (int_acks)
);

`default_nettype wire

//--- tb_mem_top.sv
`default_nettype none

module tb_mem_top
    import gba_mem_pkg::*;
();

    typedef enum logic [1:0] {
        op_read,
        op_write,
        op_gfx
    } op_kind_t;

    logic        clock;
    logic        reset;
    word_t       bus_addr;
    word_t       bus_wdata;
    word_t       bus_rdata;
    mem_size_t   bus_size;
    logic        bus_pause;
    logic        bus_write;
    word_t       gfx_vram_addr;
    word_t       gfx_vram_data;
    word_t       gfx_palette_bg_addr;
    word_t       gfx_palette_bg_data;
    word_t       gfx_palette_obj_addr;
    word_t       gfx_palette_obj_data;
    logic [15:0] buttons;
    logic [15:0] vcount;
    logic [15:0] reg_if;
    logic [15:0] int_acks;

    // Operation table
    op_kind_t  op_kind [$];
    word_t     op_addr [$];
    mem_size_t op_size [$];
    word_t     op_data [$];
    bit        op_ack [$];

    // Reference memory, one entry per canonical word address
    word_t       model [word_t];
    logic [15:0] ack_expect;
    int          value_errors;
    int          protocol_errors;
    int          cycle_count;
    int          cycle_limit;

    mem_top i_dut (
        .clock               (clock),
        .reset               (reset),
        .bus_addr            (bus_addr),
        .bus_wdata           (bus_wdata),
        .bus_rdata           (bus_rdata),
        .bus_size            (bus_size),
        .bus_pause           (bus_pause),
        .bus_write           (bus_write),
        .gfx_vram_addr       (gfx_vram_addr),
        .gfx_vram_data       (gfx_vram_data),
        .gfx_palette_bg_addr (gfx_palette_bg_addr),
        .gfx_palette_bg_data (gfx_palette_bg_data),
        .gfx_palette_obj_addr(gfx_palette_obj_addr),
        .gfx_palette_obj_data(gfx_palette_obj_data),
        .buttons             (buttons),
        .vcount              (vcount),
        .reg_if              (reg_if),
        .int_acks            (int_acks)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    // Run length limit
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run went past %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_value(string name, word_t got, word_t expected);
        if (got !== expected) begin
            $display("FAIL %s: got %h, expected %h", name, got, expected);
            value_errors++;
        end
    endtask

    task automatic protocol_error(string what);
        $display("ERROR: %s", what);
        protocol_errors++;
    endtask

    task automatic add_write(word_t addr, mem_size_t size, bit ack);
        op_kind.push_back(op_write);
        op_addr.push_back(addr);
        op_size.push_back(size);
        op_data.push_back($urandom());
        op_ack.push_back(ack);
    endtask

    task automatic add_access(op_kind_t kind, word_t addr);
        op_kind.push_back(kind);
        op_addr.push_back(addr);
        op_size.push_back(size_word);
        op_data.push_back('0);
        op_ack.push_back(1'b0);
    endtask

    // Mirrors fold onto one key per physical word
    function automatic word_t word_key(word_t addr);
        case (addr[31:24])
            region_intern:  return addr & 32'hff00_0ffc;
            region_palette: return addr & 32'hff00_03fc;
            region_vram:    return addr & 32'hff00_1ffc;
            default:        return addr & 32'hffff_fffc;
        endcase
    endfunction

    function automatic logic is_mapped(word_t addr);
        case (addr[31:24])
            region_intern, region_palette, region_vram: return 1'b1;
            region_io: return (addr[23:10] == '0) && (int'(addr[9:2]) < io_num_regs);
            default:   return 1'b0;
        endcase
    endfunction

    function automatic byte_en_t lanes_for(mem_size_t size, logic [1:0] low);
        case (size)
            size_byte: return 4'b0001 << low;
            size_half: return low[1] ? 4'b1100 : 4'b0011;
            size_word: return 4'b1111;
            default:   return 4'b0000;
        endcase
    endfunction

    function automatic word_t stored_word(word_t addr);
        word_t key;
        key = word_key(addr);
        return model.exists(key) ? model[key] : '0;
    endfunction

    task automatic model_write(word_t addr, word_t data, mem_size_t size);
        word_t    merged;
        byte_en_t en;
        if (is_mapped(addr)) begin
            merged = stored_word(addr);
            en = lanes_for(size, addr[1:0]);
            for (int b = 0; b < 4; b++) begin
                if (en[b]) begin
                    merged[8*b +: 8] = data[8*b +: 8];
                end
            end
            model[word_key(addr)] = merged;
        end
    endtask

    // Read-only I/O halves come from the inputs, not the stored word
    function automatic word_t expected_read(word_t addr);
        word_t stored;
        int    idx;
        if (!is_mapped(addr)) begin
            return '0;
        end
        stored = stored_word(addr);
        idx = int'(addr[9:2]);
        if (addr[31:24] != region_io) begin
            return stored;
        end
        if (idx == io_keyinput_idx) begin
            return {stored[31:16], buttons};
        end
        if (idx == io_vcount_idx) begin
            return {vcount, stored[15:0]};
        end
        if (idx == io_if_idx) begin
            return {reg_if, stored[15:0]};
        end
        return stored;
    endfunction

    // First cycle of every operation, no pause and only a due acknowledge
    task automatic check_idle_cycle();
        @(negedge clock);
        if (bus_pause) begin
            protocol_error("bus_pause is high outside the cycle after a write");
        end
        check_value("int_acks", {16'h0000, int_acks}, {16'h0000, ack_expect});
        ack_expect = '0;
    endtask

    task automatic do_write(int i);
        int       waited;
        byte_en_t en;
        bus_addr  = op_addr[i];
        bus_wdata = op_data[i];
        bus_size  = op_size[i];
        bus_write = 1'b1;
        check_idle_cycle();
        waited = 0;
        do begin
            @(posedge clock);
            #1;
            waited++;
            @(negedge clock);
        end while (!bus_pause && waited < 4);
        if (!bus_pause) begin
            protocol_error($sformatf("No pause after the write to %h", op_addr[i]));
        end else if (waited != 1) begin
            protocol_error($sformatf("Pause came %0d cycles after the write", waited));
        end
        @(posedge clock);
        #1;
        model_write(op_addr[i], op_data[i], op_size[i]);
        en = lanes_for(op_size[i], op_addr[i][1:0]);
        ack_expect = '0;
        if (op_ack[i] && en[2]) begin
            ack_expect[7:0] = op_data[i][23:16];
        end
        if (op_ack[i] && en[3]) begin
            ack_expect[15:8] = op_data[i][31:24];
        end
        bus_write = 1'b0;
    endtask

    task automatic do_read(int i);
        bus_addr  = op_addr[i];
        bus_write = 1'b0;
        check_idle_cycle();
        @(posedge clock);
        #1;
        @(negedge clock);
        check_value("bus_rdata", bus_rdata, expected_read(op_addr[i]));
        @(posedge clock);
        #1;
    endtask

    task automatic do_gfx(int i);
        word_t addr;
        addr = op_addr[i];
        if (addr[31:24] == region_vram) begin
            gfx_vram_addr = addr;
        end else if (addr[9]) begin
            gfx_palette_obj_addr = addr;
        end else begin
            gfx_palette_bg_addr = addr;
        end
        check_idle_cycle();
        @(posedge clock);
        #1;
        @(negedge clock);
        if (addr[31:24] == region_vram) begin
            check_value("gfx_vram_data", gfx_vram_data, stored_word(addr));
        end else if (addr[9]) begin
            check_value("gfx_palette_obj_data", gfx_palette_obj_data, stored_word(addr));
        end else begin
            check_value("gfx_palette_bg_data", gfx_palette_bg_data, stored_word(addr));
        end
        @(posedge clock);
        #1;
    endtask

    task automatic build_table();
        // Word writes to each region, read back, unmapped region reads zero
        add_write(32'h0300_0010, size_word, 1'b0);
        add_access(op_read, 32'h0300_0010);
        add_write(32'h0500_0020, size_word, 1'b0);
        add_write(32'h0500_0220, size_word, 1'b0);
        add_access(op_read, 32'h0500_0020);
        add_access(op_read, 32'h0500_0220);
        add_write(32'h0600_0040, size_word, 1'b0);
        add_access(op_read, 32'h0600_0040);
        add_write(32'h0400_0008, size_word, 1'b0);
        add_access(op_read, 32'h0400_0008);
        add_access(op_read, 32'h0700_0000);
        // Byte and halfword lanes
        add_write(32'h0300_0010, size_byte, 1'b0);
        add_access(op_read, 32'h0300_0010);
        add_write(32'h0300_0011, size_byte, 1'b0);
        add_write(32'h0300_0012, size_byte, 1'b0);
        add_write(32'h0300_0013, size_byte, 1'b0);
        add_access(op_read, 32'h0300_0010);
        add_write(32'h0300_0010, size_half, 1'b0);
        add_write(32'h0300_0012, size_half, 1'b0);
        add_access(op_read, 32'h0300_0010);
        add_write(32'h0500_0221, size_byte, 1'b0);
        add_access(op_read, 32'h0500_0220);
        add_write(32'h0600_0042, size_half, 1'b0);
        add_access(op_read, 32'h0600_0040);
        add_write(32'h0400_000b, size_byte, 1'b0);
        add_access(op_read, 32'h0400_0008);
        // Graphics ports and mirrors
        add_access(op_gfx, 32'h0600_0040);
        add_access(op_gfx, 32'h0500_0020);
        add_access(op_gfx, 32'h0500_0220);
        add_access(op_read, 32'h0300_1010);
        add_access(op_read, 32'h0600_2040);
        // Registers with read-only halves
        add_write(32'h0400_0130, size_word, 1'b0);
        add_access(op_read, 32'h0400_0130);
        add_write(32'h0400_0004, size_word, 1'b0);
        add_access(op_read, 32'h0400_0004);
        add_write(32'h0400_0200, size_half, 1'b0);
        add_access(op_read, 32'h0400_0200);
        // Interrupt acknowledge and an offset past the register file
        add_write(32'h0400_0200, size_word, 1'b1);
        add_access(op_read, 32'h0400_0200);
        add_write(32'h0400_0202, size_half, 1'b1);
        add_write(32'h0400_0203, size_byte, 1'b1);
        add_access(op_read, 32'h0400_0200);
        add_write(32'h0400_0400, size_word, 1'b0);
        add_access(op_read, 32'h0400_0400);
    endtask

    initial begin
        reset                = 1'b1;
        bus_addr             = '0;
        bus_wdata            = '0;
        bus_size             = size_word;
        bus_write            = 1'b0;
        gfx_vram_addr        = '0;
        gfx_palette_bg_addr  = '0;
        gfx_palette_obj_addr = '0;
        buttons              = '0;
        vcount               = '0;
        reg_if               = '0;
        ack_expect           = '0;
        value_errors         = 0;
        protocol_errors      = 0;
        cycle_count          = 0;
        void'($urandom(32'hff2f_b1ab));
        build_table();
        cycle_limit = op_kind.size() * 4 + 50;
        buttons = 16'($urandom());
        vcount  = 16'($urandom());
        reg_if  = 16'($urandom());
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;

        for (int i = 0; i < op_kind.size(); i++) begin
            case (op_kind[i])
                op_write: do_write(i);
                op_read:  do_read(i);
                default:  do_gfx(i);
            endcase
        end
        check_idle_cycle();

        $display("Summary: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
gba_mem_pkg.sv
dual_port_ram.sv
bus_front_end.sv
palette_mem.sv
vram_mem.sv
io_registers.sv
mem_top.sv
mem_top_assert.sv
tb_mem_top.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log

rm -f sim.log
verilator --binary --assert -f project.f --top-module tb_mem_top -o sim_mem_top \
    && ./obj_dir/sim_mem_top 2>&1 | tee sim.log

grep -qs "Checks failed" sim.log && { echo "Simulation reported failures"; exit 1; }
grep -qs "All checks passed" sim.log || { echo "Simulation did not complete"; exit 1; }
exit 0
